// ==== tb.f ====
hw/bus_pkg.sv
hw/xbar.sv
hw/sram_slave.sv
hw/clint_slave.sv
hw/uart_slave.sv
hw/soc_bus_top.sv
sim/bus_checker.sv
sim/tb_top.sv

// ==== run.sh ====
#!/bin/sh
verilator --binary --timing --assert -Wno-fatal --top-module tb_top -f tb.f -o tb_sim &&
  ./obj_dir/tb_sim | tee /dev/stderr | grep -q "^No errors$" &&
  echo "simulation passed" || { echo "simulation failed"; exit 1; }

// ==== sim/tb_top.sv ====
`timescale 1ns/1ps

module tb_top;
  import bus_pkg::*;

  localparam int sram_words = 256;

  logic              clk;
  logic              rstn;
  logic              ar_valid, ar_ready, r_valid, r_ready;
  logic              aw_valid, aw_ready, w_valid, w_ready, b_valid, b_ready;
  logic [addr_w-1:0] ar_addr, aw_addr;
  logic [data_w-1:0] r_data, w_data;
  logic [strb_w-1:0] w_strb;
  logic [1:0]        r_resp, b_resp;
  logic              tx_valid;
  logic [7:0]        tx_byte;
  logic [127:0]      cur_name;
  logic              finished;
  logic              ar_hs, r_hs, aw_hs, w_hs, b_hs;
  logic [31:0]       lfsr;
  int                errors;
  int                drv_errors;
  int                n_tests;

  // op 0 read, 1 write, 2 unmapped read, 3 unmapped write
  logic [127:0] t_name [$];
  int           t_op [$];
  logic [31:0]  t_addr [$];
  logic [31:0]  t_data [$];
  logic [3:0]   t_strb [$];
  int           t_bp [$];

  soc_bus_top #(.sram_words(sram_words)) u_dut (.*);

  bus_checker #(.sram_words(sram_words)) u_chk (.*);

  always #50 clk = ~clk;

  // handshakes as seen at the last rising edge
  always @(posedge clk) begin
    ar_hs <= ar_valid & ar_ready;
    r_hs  <= r_valid & r_ready;
    aw_hs <= aw_valid & aw_ready;
    w_hs  <= w_valid & w_ready;
    b_hs  <= b_valid & b_ready;
  end

  // fibonacci lfsr, taps 32 22 2 1
  function automatic logic lfsr_bit();
    lfsr = {lfsr[30:0], lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0]};
    return lfsr[0];
  endfunction

  task automatic add_entry(input logic [127:0] name, input int op, input logic [31:0] addr,
                           input logic [31:0] data, input logic [3:0] strb, input int bp);
    t_name.push_back(name);
    t_op.push_back(op);
    t_addr.push_back(addr);
    t_data.push_back(data);
    t_strb.push_back(strb);
    t_bp.push_back(bp);
  endtask

  task automatic note_fail(input string msg);
    $display("driver: %0s in test %0s", msg, cur_name);
    drv_errors++;
  endtask

  // ready stays low for bp cycles of valid, then follows lfsr bits
  // a second address is offered while the response is stalled
  task automatic take_resp(input bit is_rd, input int bp);
    int   seen;
    int   t;
    logic rdy;
    seen = 0;
    t = 0;
    do begin
      rdy = 1'b0;
      if (is_rd ? r_valid : b_valid) begin
        rdy = seen >= bp && (lfsr_bit() || seen >= bp + 2);
        seen++;
      end
      r_ready = is_rd & rdy;
      b_ready = !is_rd & rdy;
      ar_valid = is_rd & !rdy;
      aw_valid = !is_rd & !rdy;
      @(negedge clk);
      t++;
    end while (!(is_rd ? r_hs : b_hs) && t < 40);
    r_ready = 1'b0;
    b_ready = 1'b0;
    ar_valid = 1'b0;
    aw_valid = 1'b0;
    if (!(is_rd ? r_hs : b_hs)) note_fail("response handshake never completed");
  endtask

  task automatic do_read(input logic [31:0] addr, input int bp);
    int t;
    ar_valid = 1'b1;
    ar_addr = addr;
    t = 0;
    do begin
      @(negedge clk);
      t++;
    end while (!ar_hs && t < 30);
    ar_valid = 1'b0;
    if (!ar_hs) note_fail("read address was never accepted");
    take_resp(1'b1, bp);
  endtask

  task automatic do_write(input logic [31:0] addr, input logic [31:0] data,
                          input logic [3:0] strb, input int bp);
    int t;
    aw_valid = 1'b1;
    aw_addr = addr;
    w_valid = 1'b1;
    w_data = data;
    w_strb = strb;
    t = 0;
    do begin
      @(negedge clk);
      t++;
      if (aw_hs) aw_valid = 1'b0;
    end while (!w_hs && t < 30);
    aw_valid = 1'b0;
    w_valid = 1'b0;
    if (!w_hs) note_fail("write data was never accepted");
    take_resp(1'b0, bp);
  endtask

  // request stays up 20 cycles, then is withdrawn
  task automatic try_unmapped(input bit is_rd, input logic [31:0] addr);
    ar_valid = is_rd;
    ar_addr = addr;
    aw_valid = !is_rd;
    aw_addr = addr;
    repeat (20) begin
      @(negedge clk);
      if (ar_hs || aw_hs) note_fail("unmapped address was accepted");
    end
    ar_valid = 1'b0;
    aw_valid = 1'b0;
  endtask

  initial begin
    clk = 1'b0;
    rstn = 1'b1;
    ar_valid = 1'b0;
    ar_addr = '0;
    r_ready = 1'b0;
    aw_valid = 1'b0;
    aw_addr = '0;
    w_valid = 1'b0;
    w_data = '0;
    w_strb = '0;
    b_ready = 1'b0;
    cur_name = '0;
    finished = 1'b0;
    drv_errors = 0;
    lfsr = 32'h0dd5_19df;
    add_entry("sram_full_wr", 1, 32'h8000_0010, 32'hdead_beef, 4'hf, 0);
    add_entry("sram_full_rd", 0, 32'h8000_0010, 32'h0, 4'h0, 0);
    add_entry("sram_part_wr", 1, 32'h8000_0010, 32'h1122_3344, 4'b0101, 2);
    add_entry("sram_part_rd", 0, 32'h8000_0010, 32'h0, 4'h0, 3);
    // 0x410 lands on the same word as 0x010 with 256 words
    add_entry("sram_alias_wr", 1, 32'h8000_0410, 32'hcafe_f00d, 4'b1100, 0);
    add_entry("sram_alias_rd", 0, 32'h8000_0010, 32'h0, 4'h0, 1);
    add_entry("sram_top_wr", 1, 32'h87ff_fffc, 32'h0bad_c0de, 4'hf, 4);
    add_entry("sram_top_rd", 0, 32'h87ff_fffc, 32'h0, 4'h0, 5);
    add_entry("clint_lo", 0, 32'ha000_0048, 32'h0, 4'h0, 0);
    add_entry("clint_hi", 0, 32'ha000_004c, 32'h0, 4'h0, 2);
    add_entry("uart_a", 1, 32'ha000_03f8, 32'h0000_0041, 4'h1, 0);
    add_entry("uart_b", 1, 32'ha000_03f8, 32'hffff_ff42, 4'hf, 3);
    add_entry("bad_rd", 2, 32'h9000_0000, 32'h0, 4'h0, 0);
    add_entry("bad_clint_wr", 3, 32'ha000_0048, 32'h0, 4'h0, 0);
    add_entry("bad_uart_rd", 2, 32'ha000_03f8, 32'h0, 4'h0, 0);
    add_entry("sram_after_bad", 0, 32'h87ff_fffc, 32'h0, 4'h0, 0);
    add_entry("clint_lo_late", 0, 32'ha000_0048, 32'h0, 4'h0, 4);
    n_tests = t_op.size();
    repeat (3) @(posedge clk);
    @(negedge clk);
    rstn = 1'b0;
    for (int i = 0; i < n_tests; i++) begin
      cur_name = t_name[i];
      case (t_op[i])
        0: do_read(t_addr[i], t_bp[i]);
        1: do_write(t_addr[i], t_data[i], t_strb[i], t_bp[i]);
        2: try_unmapped(1'b1, t_addr[i]);
        default: try_unmapped(1'b0, t_addr[i]);
      endcase
    end
    finished = 1'b1;
    repeat (3) @(negedge clk);
    $display("checker errors %0d, driver errors %0d", errors, drv_errors);
    if (errors == 0 && drv_errors == 0) begin
      $display("No errors");
    end else begin
      $display("Errors found");
    end
    $finish;
  end

  initial begin
    wait (n_tests > 0);
    repeat (n_tests * 40 + 10) @(posedge clk);
    $display("watchdog: run did not finish within %0d cycles", n_tests * 40 + 10);
    $display("Errors found");
    $finish;
  end

endmodule

// ==== sim/bus_checker.sv ====
`timescale 1ns/1ps

module bus_checker #(
  parameter int sram_words = 1024
) (
  input  logic                        clk,
  input  logic                        rstn,
  input  logic                        ar_valid, ar_ready, r_valid, r_ready,
  input  logic [bus_pkg::addr_w-1:0]  ar_addr,
  input  logic [bus_pkg::data_w-1:0]  r_data,
  input  logic [1:0]                  r_resp,
  input  logic                        aw_valid, aw_ready, w_valid, w_ready,
  input  logic [bus_pkg::addr_w-1:0]  aw_addr,
  input  logic [bus_pkg::data_w-1:0]  w_data,
  input  logic [bus_pkg::strb_w-1:0]  w_strb,
  input  logic                        b_valid, b_ready,
  input  logic [1:0]                  b_resp,
  input  logic                        tx_valid,
  input  logic [7:0]                  tx_byte,
  input  logic [127:0]                cur_name,
  input  logic                        finished,
  output int                          errors
);
  import bus_pkg::*;

  logic [data_w-1:0] shadow [sram_words];
  logic [63:0]       cycles;
  logic [addr_w-1:0] wr_addr;
  logic [data_w-1:0] exp_r, last_r;
  logic [1:0]        last_b;
  logic [7:0]        tx_exp [$];
  logic              rd_busy, wr_busy, r_due, b_due, r_stall, b_stall, closed;

  initial errors = 0;

  function automatic int word_of(input logic [addr_w-1:0] a);
    return int'(a[31:2]) % sram_words;
  endfunction

  function automatic bit is_sram(input logic [addr_w-1:0] a);
    return a[31:27] == sram_region;
  endfunction

  task automatic compare(input string what, input logic [31:0] exp, input logic [31:0] act);
    if (exp !== act) begin
      $display("ERROR %0s %0s: expected %h, actual %h", cur_name, what, exp, act);
      errors++;
    end
  endtask

  task automatic complain(input string msg);
    $display("%0s in test %0s", msg, cur_name);
    errors++;
  endtask

  always @(posedge clk) begin
    if (rstn) begin
      cycles = '0;
      rd_busy = 1'b0;
      wr_busy = 1'b0;
      r_due = 1'b0;
      b_due = 1'b0;
      r_stall = 1'b0;
      b_stall = 1'b0;
      closed = 1'b0;
    end else begin
      // response latency and hold under back-pressure
      if (r_due && !r_valid) complain("r_valid missing one cycle after the read address");
      if (b_due && !b_valid) complain("b_valid missing one cycle after the write data");
      if (r_stall && !r_valid) complain("r_valid dropped without r_ready");
      if (b_stall && !b_valid) complain("b_valid dropped without b_ready");
      if (r_stall) compare("r_data hold", last_r, r_data);
      if (b_stall) compare("b_resp hold", 32'(last_b), 32'(b_resp));
      r_due = 1'b0;
      b_due = 1'b0;

      if (ar_valid && ar_ready) begin
        if (rd_busy) complain("read address accepted while a read was outstanding");
        if (is_sram(ar_addr)) begin
          exp_r = shadow[word_of(ar_addr)];
        end else if (ar_addr[31:3] == clint_mtime_lo[31:3]) begin
          // timer value at the handshake edge
          exp_r = ar_addr[2] ? cycles[63:32] : cycles[31:0];
        end else begin
          complain("unmapped read address was accepted");
        end
        rd_busy = 1'b1;
        r_due = 1'b1;
      end
      if (r_valid && r_ready) begin
        compare("r_data", exp_r, r_data);
        compare("r_resp", 32'(resp_okay), 32'(r_resp));
        rd_busy = 1'b0;
      end

      if (aw_valid && aw_ready) begin
        if (wr_busy) complain("write address accepted while a write was outstanding");
        if (!is_sram(aw_addr) && aw_addr != uart_tx_addr) begin
          complain("unmapped write address was accepted");
        end
        wr_addr = aw_addr;
        wr_busy = 1'b1;
      end
      if (w_valid && w_ready) begin
        if (is_sram(wr_addr)) begin
          for (int i = 0; i < strb_w; i++) begin
            if (w_strb[i]) shadow[word_of(wr_addr)][i*8 +: 8] = w_data[i*8 +: 8];
          end
        end else begin
          tx_exp.push_back(w_data[7:0]);
        end
        b_due = 1'b1;
      end
      if (b_valid && b_ready) begin
        compare("b_resp", 32'(resp_okay), 32'(b_resp));
        wr_busy = 1'b0;
      end

      // bytes leave the uart in write order
      if (tx_valid) begin
        if (tx_exp.size() == 0) begin
          complain("tx_valid seen with no byte written");
        end else begin
          compare("tx_byte", 32'(tx_exp.pop_front()), 32'(tx_byte));
        end
      end
      if (finished && !closed) begin
        if (tx_exp.size() != 0) complain("a written uart byte never appeared on tx");
        closed = 1'b1;
      end

      r_stall = r_valid && !r_ready;
      b_stall = b_valid && !b_ready;
      last_r = r_data;
      last_b = b_resp;
      cycles = cycles + 64'd1;
    end
  end

endmodule

// ==== hw/soc_bus_top.sv ====
`timescale 1ns/1ps

module soc_bus_top #(
  parameter int sram_words = 1024
) (
  input  logic                        clk,
  input  logic                        rstn,
  input  logic                        ar_valid,
  output logic                        ar_ready,
  input  logic [bus_pkg::addr_w-1:0]  ar_addr,
  output logic                        r_valid,
  input  logic                        r_ready,
  output logic [bus_pkg::data_w-1:0]  r_data,
  output logic [1:0]                  r_resp,
  input  logic                        aw_valid,
  output logic                        aw_ready,
  input  logic [bus_pkg::addr_w-1:0]  aw_addr,
  input  logic                        w_valid,
  output logic                        w_ready,
  input  logic [bus_pkg::data_w-1:0]  w_data,
  input  logic [bus_pkg::strb_w-1:0]  w_strb,
  output logic                        b_valid,
  input  logic                        b_ready,
  output logic [1:0]                  b_resp,
  output logic                        tx_valid,
  output logic [7:0]                  tx_byte
);
  import bus_pkg::*;

  logic              sram_ar_valid, sram_ar_ready, sram_r_valid, sram_r_ready;
  logic [addr_w-1:0] sram_ar_addr, sram_aw_addr;
  logic [data_w-1:0] sram_r_data, sram_w_data;
  logic [1:0]        sram_r_resp, sram_b_resp;
  logic              sram_aw_valid, sram_aw_ready, sram_w_valid, sram_w_ready;
  logic [strb_w-1:0] sram_w_strb;
  logic              sram_b_valid, sram_b_ready;

  logic              clint_ar_valid, clint_ar_ready, clint_r_valid, clint_r_ready;
  logic [addr_w-1:0] clint_ar_addr;
  logic [data_w-1:0] clint_r_data;
  logic [1:0]        clint_r_resp;

  logic              uart_aw_valid, uart_aw_ready, uart_w_valid, uart_w_ready;
  logic [addr_w-1:0] uart_aw_addr;
  logic [data_w-1:0] uart_w_data;
  logic [strb_w-1:0] uart_w_strb;
  logic              uart_b_valid, uart_b_ready;
  logic [1:0]        uart_b_resp;

  // port names line up with the local nets
  xbar u_xbar (.*);

  sram_slave #(
    .sram_words (sram_words)
  ) u_sram (
    .clk      (clk),
    .rstn     (rstn),
    .ar_valid (sram_ar_valid),
    .ar_ready (sram_ar_ready),
    .ar_addr  (sram_ar_addr),
    .r_valid  (sram_r_valid),
    .r_ready  (sram_r_ready),
    .r_data   (sram_r_data),
    .r_resp   (sram_r_resp),
    .aw_valid (sram_aw_valid),
    .aw_ready (sram_aw_ready),
    .aw_addr  (sram_aw_addr),
    .w_valid  (sram_w_valid),
    .w_ready  (sram_w_ready),
    .w_data   (sram_w_data),
    .w_strb   (sram_w_strb),
    .b_valid  (sram_b_valid),
    .b_ready  (sram_b_ready),
    .b_resp   (sram_b_resp)
  );

  clint_slave u_clint (
    .clk      (clk),
    .rstn     (rstn),
    .ar_valid (clint_ar_valid),
    .ar_ready (clint_ar_ready),
    .ar_addr  (clint_ar_addr),
    .r_valid  (clint_r_valid),
    .r_ready  (clint_r_ready),
    .r_data   (clint_r_data),
    .r_resp   (clint_r_resp)
  );

  uart_slave u_uart (
    .clk      (clk),
    .rstn     (rstn),
    .aw_valid (uart_aw_valid),
    .aw_ready (uart_aw_ready),
    .aw_addr  (uart_aw_addr),
    .w_valid  (uart_w_valid),
    .w_ready  (uart_w_ready),
    .w_data   (uart_w_data),
    .w_strb   (uart_w_strb),
    .b_valid  (uart_b_valid),
    .b_ready  (uart_b_ready),
    .b_resp   (uart_b_resp),
    .tx_valid (tx_valid),
    .tx_byte  (tx_byte)
  );

endmodule

// ==== hw/uart_slave.sv ====
`timescale 1ns/1ps

module uart_slave (
  input  logic                        clk,
  input  logic                        rstn,
  input  logic                        aw_valid,
  output logic                        aw_ready,
  input  logic [bus_pkg::addr_w-1:0]  aw_addr,
  input  logic                        w_valid,
  output logic                        w_ready,
  input  logic [bus_pkg::data_w-1:0]  w_data,
  input  logic [bus_pkg::strb_w-1:0]  w_strb,
  output logic                        b_valid,
  input  logic                        b_ready,
  output logic [1:0]                  b_resp,
  output logic                        tx_valid,
  output logic [7:0]                  tx_byte
);
  import bus_pkg::*;

  logic aw_done;

  assign aw_ready = ~aw_done & ~b_valid;
  assign w_ready  = aw_done;
  assign b_resp   = resp_okay;

  always_ff @(posedge clk) begin
    if (rstn) begin
      aw_done  <= 1'b0;
      b_valid  <= 1'b0;
      tx_valid <= 1'b0;
    end else begin
      if (aw_valid && aw_ready) begin
        aw_done <= 1'b1;
      end else if (w_valid && w_ready) begin
        aw_done <= 1'b0;
      end

      if (w_valid && w_ready) begin
        b_valid <= 1'b1;
      end else if (b_valid && b_ready) begin
        b_valid <= 1'b0;
      end

      // one strobe per accepted byte lane 0
      tx_valid <= w_valid & w_ready & w_strb[0];
    end
  end

  always_ff @(posedge clk) begin
    if (w_valid && w_ready) begin
      tx_byte <= w_data[7:0];
    end
  end

  a_tx_pulse: assert property (@(posedge clk) disable iff (rstn)
    tx_valid |=> !tx_valid);

  // only the transmit register is decoded to this slave
  a_tx_addr: assert property (@(posedge clk) disable iff (rstn)
    (aw_valid && aw_ready) |-> (aw_addr == uart_tx_addr));

endmodule

// ==== hw/clint_slave.sv ====
`timescale 1ns/1ps

module clint_slave (
  input  logic                        clk,
  input  logic                        rstn,
  input  logic                        ar_valid,
  output logic                        ar_ready,
  input  logic [bus_pkg::addr_w-1:0]  ar_addr,
  output logic                        r_valid,
  input  logic                        r_ready,
  output logic [bus_pkg::data_w-1:0]  r_data,
  output logic [1:0]                  r_resp
);
  import bus_pkg::*;

  logic [63:0] mtime;

  assign ar_ready = ~r_valid;
  assign r_resp   = resp_okay;

  // free-running machine timer
  always_ff @(posedge clk) begin
    if (rstn) begin
      mtime <= '0;
    end else begin
      mtime <= mtime + 64'd1;
    end
  end

  always_ff @(posedge clk) begin
    if (rstn) begin
      r_valid <= 1'b0;
    end else if (ar_valid && ar_ready) begin
      r_valid <= 1'b1;
    end else if (r_valid && r_ready) begin
      r_valid <= 1'b0;
    end
  end

  // bit 2 picks the half, sampled at the handshake
  always_ff @(posedge clk) begin
    if (ar_valid && ar_ready) begin
      r_data <= ar_addr[2] ? mtime[63:32] : mtime[31:0];
    end
  end

endmodule

// ==== hw/sram_slave.sv ====
`timescale 1ns/1ps

module sram_slave #(
  parameter int sram_words = 1024
) (
  input  logic                        clk,
  input  logic                        rstn,
  input  logic                        ar_valid,
  output logic                        ar_ready,
  input  logic [bus_pkg::addr_w-1:0]  ar_addr,
  output logic                        r_valid,
  input  logic                        r_ready,
  output logic [bus_pkg::data_w-1:0]  r_data,
  output logic [1:0]                  r_resp,
  input  logic                        aw_valid,
  output logic                        aw_ready,
  input  logic [bus_pkg::addr_w-1:0]  aw_addr,
  input  logic                        w_valid,
  output logic                        w_ready,
  input  logic [bus_pkg::data_w-1:0]  w_data,
  input  logic [bus_pkg::strb_w-1:0]  w_strb,
  output logic                        b_valid,
  input  logic                        b_ready,
  output logic [1:0]                  b_resp
);
  import bus_pkg::*;

  localparam int idx_w = $clog2(sram_words);

  logic [data_w-1:0] mem [sram_words];
  logic [idx_w-1:0]  rd_idx, wr_idx;
  logic              aw_done;

  // word index, wraps at the depth
  assign rd_idx = ar_addr[idx_w+1:2];

  assign ar_ready = ~r_valid;
  assign aw_ready = ~aw_done & ~b_valid;
  assign w_ready  = aw_done;
  assign r_resp   = resp_okay;
  assign b_resp   = resp_okay;

  always_ff @(posedge clk) begin
    if (rstn) begin
      r_valid <= 1'b0;
      aw_done <= 1'b0;
      b_valid <= 1'b0;
    end else begin
      if (ar_valid && ar_ready) begin
        r_valid <= 1'b1;
      end else if (r_valid && r_ready) begin
        r_valid <= 1'b0;
      end

      if (aw_valid && aw_ready) begin
        aw_done <= 1'b1;
      end else if (w_valid && w_ready) begin
        aw_done <= 1'b0;
      end

      if (w_valid && w_ready) begin
        b_valid <= 1'b1;
      end else if (b_valid && b_ready) begin
        b_valid <= 1'b0;
      end
    end
  end

  // storage and captured payload
  always_ff @(posedge clk) begin
    if (ar_valid && ar_ready) begin
      r_data <= mem[rd_idx];
    end
    if (aw_valid && aw_ready) begin
      wr_idx <= aw_addr[idx_w+1:2];
    end
    if (w_valid && w_ready) begin
      for (int i = 0; i < strb_w; i++) begin
        if (w_strb[i]) begin
          mem[wr_idx][i*8 +: 8] <= w_data[i*8 +: 8];
        end
      end
    end
  end

  // the crossbar only forwards data once the address is locked here
  a_w_after_aw: assert property (@(posedge clk) disable iff (rstn)
    w_valid |-> aw_done);

endmodule

// ==== hw/xbar.sv ====
`timescale 1ns/1ps

module xbar (
  input  logic                        clk,
  input  logic                        rstn,

  // master read
  input  logic                        ar_valid,
  output logic                        ar_ready,
  input  logic [bus_pkg::addr_w-1:0]  ar_addr,
  output logic                        r_valid,
  input  logic                        r_ready,
  output logic [bus_pkg::data_w-1:0]  r_data,
  output logic [1:0]                  r_resp,

  // master write
  input  logic                        aw_valid,
  output logic                        aw_ready,
  input  logic [bus_pkg::addr_w-1:0]  aw_addr,
  input  logic                        w_valid,
  output logic                        w_ready,
  input  logic [bus_pkg::data_w-1:0]  w_data,
  input  logic [bus_pkg::strb_w-1:0]  w_strb,
  output logic                        b_valid,
  input  logic                        b_ready,
  output logic [1:0]                  b_resp,

  // sram, read and write
  output logic                        sram_ar_valid,
  input  logic                        sram_ar_ready,
  output logic [bus_pkg::addr_w-1:0]  sram_ar_addr,
  input  logic                        sram_r_valid,
  output logic                        sram_r_ready,
  input  logic [bus_pkg::data_w-1:0]  sram_r_data,
  input  logic [1:0]                  sram_r_resp,
  output logic                        sram_aw_valid,
  input  logic                        sram_aw_ready,
  output logic [bus_pkg::addr_w-1:0]  sram_aw_addr,
  output logic                        sram_w_valid,
  input  logic                        sram_w_ready,
  output logic [bus_pkg::data_w-1:0]  sram_w_data,
  output logic [bus_pkg::strb_w-1:0]  sram_w_strb,
  input  logic                        sram_b_valid,
  output logic                        sram_b_ready,
  input  logic [1:0]                  sram_b_resp,

  // clint, read only
  output logic                        clint_ar_valid,
  input  logic                        clint_ar_ready,
  output logic [bus_pkg::addr_w-1:0]  clint_ar_addr,
  input  logic                        clint_r_valid,
  output logic                        clint_r_ready,
  input  logic [bus_pkg::data_w-1:0]  clint_r_data,
  input  logic [1:0]                  clint_r_resp,

  // uart, write only
  output logic                        uart_aw_valid,
  input  logic                        uart_aw_ready,
  output logic [bus_pkg::addr_w-1:0]  uart_aw_addr,
  output logic                        uart_w_valid,
  input  logic                        uart_w_ready,
  output logic [bus_pkg::data_w-1:0]  uart_w_data,
  output logic [bus_pkg::strb_w-1:0]  uart_w_strb,
  input  logic                        uart_b_valid,
  output logic                        uart_b_ready,
  input  logic [1:0]                  uart_b_resp
);
  import bus_pkg::*;

  logic rd_idle, rd_sram, rd_clint;
  logic wr_idle, wr_sram, wr_uart;

  // address decode
  logic rd_hit_sram, rd_hit_clint;
  logic wr_hit_sram, wr_hit_uart;

  assign rd_hit_sram  = (ar_addr[addr_w-1 -: 5] == sram_region);
  assign rd_hit_clint = (ar_addr[addr_w-1:3] == clint_mtime_lo[addr_w-1:3]);
  assign wr_hit_sram  = (aw_addr[addr_w-1 -: 5] == sram_region);
  assign wr_hit_uart  = (aw_addr == uart_tx_addr);

  // read request steering; unmapped addresses see ready low forever
  assign sram_ar_addr   = ar_addr;
  assign clint_ar_addr  = ar_addr;
  assign sram_ar_valid  = rd_idle & ar_valid & rd_hit_sram;
  assign clint_ar_valid = rd_idle & ar_valid & rd_hit_clint;
  assign ar_ready = rd_idle & ((rd_hit_sram & sram_ar_ready) | (rd_hit_clint & clint_ar_ready));

  // read response from the locked slave
  assign sram_r_ready  = rd_sram & r_ready;
  assign clint_r_ready = rd_clint & r_ready;

  always_comb begin
    if (rd_sram) begin
      r_valid = sram_r_valid;
      r_data  = sram_r_data;
      r_resp  = sram_r_resp;
    end else if (rd_clint) begin
      r_valid = clint_r_valid;
      r_data  = clint_r_data;
      r_resp  = clint_r_resp;
    end else begin
      r_valid = 1'b0;
      r_data  = '0;
      r_resp  = resp_okay;
    end
  end

  always_ff @(posedge clk) begin
    if (rstn) begin
      rd_idle  <= 1'b1;
      rd_sram  <= 1'b0;
      rd_clint <= 1'b0;
    end else if (ar_valid && ar_ready) begin
      rd_idle  <= 1'b0;
      rd_sram  <= rd_hit_sram;
      rd_clint <= rd_hit_clint;
    end else if (r_valid && r_ready) begin
      rd_idle  <= 1'b1;
      rd_sram  <= 1'b0;
      rd_clint <= 1'b0;
    end
  end

  // write request steering
  assign sram_aw_addr  = aw_addr;
  assign uart_aw_addr  = aw_addr;
  assign sram_aw_valid = wr_idle & aw_valid & wr_hit_sram;
  assign uart_aw_valid = wr_idle & aw_valid & wr_hit_uart;
  assign aw_ready = wr_idle & ((wr_hit_sram & sram_aw_ready) | (wr_hit_uart & uart_aw_ready));

  // data and response only towards the locked slave
  assign sram_w_valid = wr_sram & w_valid;
  assign sram_w_data  = wr_sram ? w_data : '0;
  assign sram_w_strb  = wr_sram ? w_strb : '0;
  assign sram_b_ready = wr_sram & b_ready;
  assign uart_w_valid = wr_uart & w_valid;
  assign uart_w_data  = wr_uart ? w_data : '0;
  assign uart_w_strb  = wr_uart ? w_strb : '0;
  assign uart_b_ready = wr_uart & b_ready;

  always_comb begin
    if (wr_sram) begin
      w_ready = sram_w_ready;
      b_valid = sram_b_valid;
      b_resp  = sram_b_resp;
    end else if (wr_uart) begin
      w_ready = uart_w_ready;
      b_valid = uart_b_valid;
      b_resp  = uart_b_resp;
    end else begin
      w_ready = 1'b0;
      b_valid = 1'b0;
      b_resp  = resp_okay;
    end
  end

  always_ff @(posedge clk) begin
    if (rstn) begin
      wr_idle <= 1'b1;
      wr_sram <= 1'b0;
      wr_uart <= 1'b0;
    end else if (aw_valid && aw_ready) begin
      wr_idle <= 1'b0;
      wr_sram <= wr_hit_sram;
      wr_uart <= wr_hit_uart;
    end else if (b_valid && b_ready) begin
      wr_idle <= 1'b1;
      wr_sram <= 1'b0;
      wr_uart <= 1'b0;
    end
  end

  a_one_target: assert property (@(posedge clk) disable iff (rstn)
    $onehot0({rd_sram, rd_clint}) && $onehot0({wr_sram, wr_uart}));

  // a slave must not answer a read that was never routed to it
  a_no_stray_r: assert property (@(posedge clk) disable iff (rstn)
    (sram_r_valid || clint_r_valid) |-> !rd_idle);

endmodule

// ==== hw/bus_pkg.sv ====
package bus_pkg;

  // bus geometry
  localparam int addr_w = 32;
  localparam int data_w = 32;
  localparam int strb_w = data_w / 8;

  // response codes
  localparam logic [1:0] resp_okay = 2'b00;

  // sram occupies 0x8000_0000 .. 0x87ff_ffff
  localparam logic [4:0] sram_region = 5'b10000;

  // clint mtime, low word then high word at +4
  localparam logic [addr_w-1:0] clint_mtime_lo = 32'ha000_0048;

  // uart transmit holding register
  localparam logic [addr_w-1:0] uart_tx_addr = 32'ha000_03f8;

endpackage
